//--- source/controlPkg.sv
// Shared field types, select codes, FSM states and control structs for the control unit RTL
package controlPkg;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    localparam opcode_t OP_RTYPE = 6'b000_000;
    localparam opcode_t OP_ADDI  = 6'b001_000;
    localparam opcode_t OP_ADDIU = 6'b001_001;
    localparam opcode_t OP_BEQ   = 6'b000_100;
    localparam opcode_t OP_BNE   = 6'b000_101;

    localparam funct_t FUNCT_ADD  = 6'b100_000;
    localparam funct_t FUNCT_SUB  = 6'b100_010;
    localparam funct_t FUNCT_AND  = 6'b100_100;
    localparam funct_t FUNCT_SLL  = 6'b000_000;
    localparam funct_t FUNCT_SLLV = 6'b000_100;
    localparam funct_t FUNCT_SRA  = 6'b000_011;
    localparam funct_t FUNCT_SRAV = 6'b000_111;
    localparam funct_t FUNCT_SRL  = 6'b000_010;

    // ALU operation
    typedef logic [2:0] aluOp_t;

    localparam aluOp_t ALU_ADD = 3'd1;
    localparam aluOp_t ALU_SUB = 3'd2;
    localparam aluOp_t ALU_AND = 3'd3;

    // Shifter command
    typedef logic [2:0] shiftCtrl_t;

    localparam shiftCtrl_t SH_NONE        = 3'd0;
    localparam shiftCtrl_t SH_LOAD        = 3'd1;
    localparam shiftCtrl_t SH_LEFT        = 3'd2;
    localparam shiftCtrl_t SH_RIGHT_LOGIC = 3'd3;
    localparam shiftCtrl_t SH_RIGHT_ARITH = 3'd4;

    // Two-bit datapath mux selects
    typedef logic [1:0] sel2_t;

    localparam sel2_t SRCA_PC  = 2'd0;
    localparam sel2_t SRCA_REG = 2'd2;

    localparam sel2_t SRCB_REG    = 2'd0;
    localparam sel2_t SRCB_FOUR   = 2'd1;
    localparam sel2_t SRCB_IMM    = 2'd2;
    localparam sel2_t SRCB_BRANCH = 2'd3;

    localparam sel2_t WR_RT = 2'd0;
    localparam sel2_t WR_RD = 2'd1;
    localparam sel2_t WR_SP = 2'd3;

    localparam sel2_t PC_ALU    = 2'd0;
    localparam sel2_t PC_ALUOUT = 2'd1;

    localparam sel2_t SHIN_A = 2'd0;
    localparam sel2_t SHIN_B = 2'd2;

    localparam sel2_t SHAMT_REG = 2'd0;
    localparam sel2_t SHAMT_IMM = 2'd1;

    localparam sel2_t EXC_OPCODE   = 2'd0;
    localparam sel2_t EXC_OVERFLOW = 2'd1;

    // Register file write data
    typedef logic [2:0] wdSel_t;

    localparam wdSel_t WD_ALUOUT  = 3'd0;
    localparam wdSel_t WD_SHIFT   = 3'd5;
    localparam wdSel_t WD_SP_INIT = 3'd6;

    typedef enum logic [2:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_SHIFT,
        CLS_BRANCH,
        CLS_ILLEGAL
    } instrClass_t;

    typedef enum logic [3:0] {
        stReset,
        stFetch,
        stDecode,
        stAluCompute,
        stAluWriteback,
        stShiftExec,
        stBranchExec,
        stOverflowTrap,
        stOpcodeTrap
    } ctrlState_t;

    typedef struct packed {
        instrClass_t cls;
        aluOp_t      aluOp;
        logic        trapsOverflow;
        shiftCtrl_t  shiftDir;
        // Shift B by shamt instead of A by register amount
        logic        shiftByImm;
        logic        isBne;
    } decodedInstr_t;

    typedef struct packed {
        sel2_t  exCause;
        sel2_t  wrReg;
        sel2_t  aluSrcA;
        sel2_t  aluSrcB;
        sel2_t  pcSource;
        wdSel_t wdReg;
        sel2_t  shiftIn;
        sel2_t  shiftS;
    } muxSel_t;

    typedef struct packed {
        logic       pcWrite;
        logic       eqCond;
        logic       neCond;
        logic       loadAB;
        logic       aluOutLoad;
        logic       epcWrite;
        logic       memRead;
        logic       irWrite;
        logic       regWrite;
        aluOp_t     aluOp;
        shiftCtrl_t shiftCtrl;
    } regCtrl_t;

endpackage

//--- source/instrDecoder.sv
// Combinational opcode and funct classifier feeding the control sequencer
module instrDecoder (
    input  controlPkg::opcode_t       opcode,
    input  controlPkg::funct_t        funct,
    output controlPkg::decodedInstr_t instr
);

    always_comb begin
        instr = '0;
        instr.cls = controlPkg::CLS_ILLEGAL;
        case (opcode)
            controlPkg::OP_RTYPE: begin
                case (funct)
                    controlPkg::FUNCT_ADD: begin
                        instr.cls = controlPkg::CLS_ALU_REG;
                        instr.aluOp = controlPkg::ALU_ADD;
                        instr.trapsOverflow = 1'b1;
                    end
                    controlPkg::FUNCT_SUB: begin
                        instr.cls = controlPkg::CLS_ALU_REG;
                        instr.aluOp = controlPkg::ALU_SUB;
                        instr.trapsOverflow = 1'b1;
                    end
                    controlPkg::FUNCT_AND: begin
                        instr.cls = controlPkg::CLS_ALU_REG;
                        instr.aluOp = controlPkg::ALU_AND;
                    end
                    controlPkg::FUNCT_SLL: begin
                        instr.cls = controlPkg::CLS_SHIFT;
                        instr.shiftDir = controlPkg::SH_LEFT;
                        instr.shiftByImm = 1'b1;
                    end
                    controlPkg::FUNCT_SLLV: begin
                        instr.cls = controlPkg::CLS_SHIFT;
                        instr.shiftDir = controlPkg::SH_LEFT;
                    end
                    controlPkg::FUNCT_SRA: begin
                        instr.cls = controlPkg::CLS_SHIFT;
                        instr.shiftDir = controlPkg::SH_RIGHT_ARITH;
                        instr.shiftByImm = 1'b1;
                    end
                    controlPkg::FUNCT_SRAV: begin
                        instr.cls = controlPkg::CLS_SHIFT;
                        instr.shiftDir = controlPkg::SH_RIGHT_ARITH;
                    end
                    controlPkg::FUNCT_SRL: begin
                        instr.cls = controlPkg::CLS_SHIFT;
                        instr.shiftDir = controlPkg::SH_RIGHT_LOGIC;
                        instr.shiftByImm = 1'b1;
                    end
                    default: ;
                endcase
            end
            controlPkg::OP_ADDI: begin
                instr.cls = controlPkg::CLS_ALU_IMM;
                instr.aluOp = controlPkg::ALU_ADD;
                instr.trapsOverflow = 1'b1;
            end
            // Unsigned add never traps
            controlPkg::OP_ADDIU: begin
                instr.cls = controlPkg::CLS_ALU_IMM;
                instr.aluOp = controlPkg::ALU_ADD;
            end
            controlPkg::OP_BEQ: begin
                instr.cls = controlPkg::CLS_BRANCH;
            end
            controlPkg::OP_BNE: begin
                instr.cls = controlPkg::CLS_BRANCH;
                instr.isBne = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- source/controlSequencer.sv
// Multicycle FSM with step counter; latches the decoded instruction at the end of decode
module controlSequencer #(
    parameter int MemLatency = 3,
    parameter int StepW = 2
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  controlPkg::decodedInstr_t decoded,
    input  logic                      overflow,
    output controlPkg::ctrlState_t    state,
    output logic [StepW-1:0]          step,
    output controlPkg::decodedInstr_t instr
);

    localparam logic [StepW-1:0] LastFetch = StepW'(MemLatency);
    localparam logic [StepW-1:0] StepOne = StepW'(1);
    localparam logic [StepW-1:0] StepTwo = StepW'(2);

    controlPkg::ctrlState_t nextState;
    logic                   lastStep;

    // Length of each state and where it goes once its last step is reached
    always_comb begin
        lastStep = 1'b1;
        nextState = controlPkg::stFetch;
        case (state)
            // Step 0 is the held-in-reset phase, step 1 the stack pointer write
            controlPkg::stReset: begin
                lastStep = (step == StepOne);
            end
            controlPkg::stFetch: begin
                lastStep = (step == LastFetch);
                nextState = controlPkg::stDecode;
            end
            controlPkg::stDecode: begin
                lastStep = (step == StepOne);
                case (decoded.cls)
                    controlPkg::CLS_ALU_REG,
                    controlPkg::CLS_ALU_IMM: begin
                        nextState = controlPkg::stAluCompute;
                    end
                    controlPkg::CLS_SHIFT: begin
                        nextState = controlPkg::stShiftExec;
                    end
                    controlPkg::CLS_BRANCH: begin
                        nextState = controlPkg::stBranchExec;
                    end
                    default: begin
                        nextState = controlPkg::stOpcodeTrap;
                    end
                endcase
            end
            // Overflow is valid at the closing edge of the compute cycle
            controlPkg::stAluCompute: begin
                if (instr.trapsOverflow && overflow) begin
                    nextState = controlPkg::stOverflowTrap;
                end else begin
                    nextState = controlPkg::stAluWriteback;
                end
            end
            controlPkg::stShiftExec: begin
                lastStep = (step == StepTwo);
            end
            controlPkg::stBranchExec: begin
                lastStep = (step == StepOne);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= controlPkg::stReset;
            step <= '0;
        end else if (lastStep) begin
            state <= nextState;
            step <= '0;
        end else begin
            step <= step + StepOne;
        end
    end

    // Instruction held for the whole execute sequence
    always_ff @(posedge clk) begin
        if (state == controlPkg::stDecode && lastStep) begin
            instr <= decoded;
        end
    end

endmodule

//--- source/controlSignalGen.sv
// Moore decode of state, step and latched instruction into datapath control structs
module controlSignalGen #(
    parameter int MemLatency = 3,
    parameter int StepW = 2
) (
    input  controlPkg::ctrlState_t    state,
    input  logic [StepW-1:0]          step,
    input  controlPkg::decodedInstr_t instr,
    output controlPkg::muxSel_t       muxSel,
    output controlPkg::regCtrl_t      regCtrl
);

    localparam logic [StepW-1:0] LastFetch = StepW'(MemLatency);
    localparam logic [StepW-1:0] StepOne = StepW'(1);

    logic isImm;

    assign isImm = (instr.cls == controlPkg::CLS_ALU_IMM);

    always_comb begin
        muxSel = '0;
        regCtrl = '0;
        case (state)
            controlPkg::stReset: begin
                // Stack pointer init once reset has been released
                if (step == StepOne) begin
                    regCtrl.regWrite = 1'b1;
                    muxSel.wrReg = controlPkg::WR_SP;
                    muxSel.wdReg = controlPkg::WD_SP_INIT;
                end
            end
            controlPkg::stFetch: begin
                if (step != LastFetch) begin
                    // Memory read while the ALU forms PC + 4
                    regCtrl.memRead = 1'b1;
                    muxSel.aluSrcA = controlPkg::SRCA_PC;
                    muxSel.aluSrcB = controlPkg::SRCB_FOUR;
                    regCtrl.aluOp = controlPkg::ALU_ADD;
                end else begin
                    regCtrl.pcWrite = 1'b1;
                    regCtrl.irWrite = 1'b1;
                    muxSel.pcSource = controlPkg::PC_ALU;
                end
            end
            controlPkg::stDecode: begin
                if (step == '0) begin
                    // Branch target computed early
                    regCtrl.aluOutLoad = 1'b1;
                    muxSel.aluSrcA = controlPkg::SRCA_PC;
                    muxSel.aluSrcB = controlPkg::SRCB_BRANCH;
                    regCtrl.aluOp = controlPkg::ALU_ADD;
                end else begin
                    regCtrl.loadAB = 1'b1;
                end
            end
            controlPkg::stAluCompute: begin
                regCtrl.aluOutLoad = 1'b1;
                muxSel.aluSrcA = controlPkg::SRCA_REG;
                muxSel.aluSrcB = isImm ? controlPkg::SRCB_IMM : controlPkg::SRCB_REG;
                regCtrl.aluOp = instr.aluOp;
            end
            controlPkg::stAluWriteback: begin
                regCtrl.regWrite = 1'b1;
                muxSel.wdReg = controlPkg::WD_ALUOUT;
                muxSel.wrReg = isImm ? controlPkg::WR_RT : controlPkg::WR_RD;
            end
            controlPkg::stShiftExec: begin
                if (step == '0) begin
                    regCtrl.shiftCtrl = controlPkg::SH_LOAD;
                    if (instr.shiftByImm) begin
                        muxSel.shiftIn = controlPkg::SHIN_B;
                        muxSel.shiftS = controlPkg::SHAMT_IMM;
                    end else begin
                        muxSel.shiftIn = controlPkg::SHIN_A;
                        muxSel.shiftS = controlPkg::SHAMT_REG;
                    end
                end else if (step == StepOne) begin
                    regCtrl.shiftCtrl = instr.shiftDir;
                end else begin
                    regCtrl.regWrite = 1'b1;
                    muxSel.wrReg = controlPkg::WR_RD;
                    muxSel.wdReg = controlPkg::WD_SHIFT;
                end
            end
            controlPkg::stBranchExec: begin
                // Second cycle idles while the PC update settles
                if (step == '0) begin
                    regCtrl.eqCond = !instr.isBne;
                    regCtrl.neCond = instr.isBne;
                    muxSel.pcSource = controlPkg::PC_ALUOUT;
                    muxSel.aluSrcA = controlPkg::SRCA_REG;
                    muxSel.aluSrcB = controlPkg::SRCB_REG;
                    regCtrl.aluOp = controlPkg::ALU_SUB;
                end
            end
            controlPkg::stOverflowTrap: begin
                regCtrl.epcWrite = 1'b1;
                muxSel.exCause = controlPkg::EXC_OVERFLOW;
            end
            controlPkg::stOpcodeTrap: begin
                regCtrl.epcWrite = 1'b1;
                muxSel.exCause = controlPkg::EXC_OPCODE;
            end
            default: ;
        endcase
    end

endmodule

//--- source/controlUnit.sv
// Top of the multicycle control unit; connects decoder, sequencer and signal generator
module controlUnit #(
    parameter int MemLatency = 3
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  controlPkg::opcode_t  opcode,
    input  controlPkg::funct_t   funct,
    input  logic                 overflow,
    output controlPkg::muxSel_t  muxSel,
    output controlPkg::regCtrl_t regCtrl
);

    // Counter must reach the last fetch step and the third shift step
    localparam int MaxStep = (MemLatency > 2) ? MemLatency : 2;
    localparam int StepW = $clog2(MaxStep + 1);

    controlPkg::decodedInstr_t decoded;
    controlPkg::decodedInstr_t instr;
    controlPkg::ctrlState_t    state;
    logic [StepW-1:0]          step;

    instrDecoder u_decoder (
        .opcode (opcode),
        .funct  (funct),
        .instr  (decoded)
    );

    controlSequencer #(
        .MemLatency (MemLatency),
        .StepW      (StepW)
    ) u_sequencer (
        .clk      (clk),
        .rstN     (rstN),
        .decoded  (decoded),
        .overflow (overflow),
        .state    (state),
        .step     (step),
        .instr    (instr)
    );

    controlSignalGen #(
        .MemLatency (MemLatency),
        .StepW      (StepW)
    ) u_signalGen (
        .state   (state),
        .step    (step),
        .instr   (instr),
        .muxSel  (muxSel),
        .regCtrl (regCtrl)
    );

endmodule

//--- tests/controlUnit_assertions.sv
// Concurrent checks on the control outputs, bound into controlUnit where the clock is visible
module controlUnit_assertions (
    input logic                   clk,
    input logic                   rstN,
    input controlPkg::ctrlState_t state,
    input controlPkg::regCtrl_t   regCtrl
);

    int failCount = 0;

    noWriteDuringTrap: assert property (@(posedge clk) disable iff (!rstN)
        !(regCtrl.regWrite && regCtrl.epcWrite))
    else begin
        $error("regWrite and epcWrite are high in the same cycle");
        failCount = failCount + 1;
    end

    memReadInFetch: assert property (@(posedge clk) disable iff (!rstN)
        regCtrl.memRead |-> (state == controlPkg::stFetch))
    else begin
        $error("memRead is high outside of fetch");
        failCount = failCount + 1;
    end

    oneBranchCond: assert property (@(posedge clk) disable iff (!rstN)
        !(regCtrl.eqCond && regCtrl.neCond))
    else begin
        $error("eqCond and neCond are high together");
        failCount = failCount + 1;
    end

    // A trap hands straight back to fetch
    fetchAfterTrap: assert property (@(posedge clk) disable iff (!rstN)
        regCtrl.epcWrite |=> regCtrl.memRead)
    else begin
        $error("memRead did not follow epcWrite");
        failCount = failCount + 1;
    end

endmodule

bind controlUnit controlUnit_assertions u_checks (
    .clk     (clk),
    .rstN    (rstN),
    .state   (state),
    .regCtrl (regCtrl)
);

//--- tests/controlUnitTb.sv
// Directed testbench for controlUnit; checks every control cycle against a reference table
module controlUnitTb;

    localparam int MemLatency = 3;
    localparam int ResetCycles = 4;
    // About 60 instructions of at most 9 cycles, with a wide margin
    localparam int InstrBudget = 60;
    localparam int CyclesPerInstr = 9;
    localparam int CycleLimit = 4 * InstrBudget * CyclesPerInstr;

    logic                 clk = 1'b0;
    logic                 rstN;
    controlPkg::opcode_t  opcode;
    controlPkg::funct_t   funct;
    logic                 overflow;
    controlPkg::muxSel_t  muxSel;
    controlPkg::regCtrl_t regCtrl;

    controlPkg::muxSel_t  expMux[$];
    controlPkg::regCtrl_t expReg[$];

    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    failedTests = 0;
    int    testErrors = 0;
    int    cycleCount = 0;
    int    seed = 28678;
    string testName;

    controlUnit #(
        .MemLatency (MemLatency)
    ) u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .opcode   (opcode),
        .funct    (funct),
        .overflow (overflow),
        .muxSel   (muxSel),
        .regCtrl  (regCtrl)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the run went past %0d cycles", CycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic openTest(input string name);
        testName = name;
        testErrors = errors;
        tests++;
    endtask

    task automatic closeTest();
        if (errors != testErrors) begin
            failedTests++;
        end
        $display("test %s done with %0d errors", testName, errors - testErrors);
    endtask

    task automatic checkOutputs(input controlPkg::muxSel_t m, input controlPkg::regCtrl_t r,
                                input string label, input int idx);
        checks++;
        assert (muxSel === m) else begin
            $display("FAIL %s cycle %0d: muxSel = %h, expected %h", label, idx, muxSel, m);
            errors++;
        end
        assert (regCtrl === r) else begin
            $display("FAIL %s cycle %0d: regCtrl = %h, expected %h", label, idx, regCtrl, r);
            errors++;
        end
    endtask

    task automatic pushCycle(input controlPkg::muxSel_t m, input controlPkg::regCtrl_t r);
        expMux.push_back(m);
        expReg.push_back(r);
    endtask

    task automatic fetchDecodeCycles();
        controlPkg::muxSel_t  m;
        controlPkg::regCtrl_t r;
        int                   i;
        for (i = 0; i < MemLatency; i++) begin
            m = '0;
            r = '0;
            r.memRead = 1'b1;
            m.aluSrcA = controlPkg::SRCA_PC;
            m.aluSrcB = controlPkg::SRCB_FOUR;
            r.aluOp = controlPkg::ALU_ADD;
            pushCycle(m, r);
        end
        m = '0;
        r = '0;
        r.pcWrite = 1'b1;
        r.irWrite = 1'b1;
        m.pcSource = controlPkg::PC_ALU;
        pushCycle(m, r);
        m = '0;
        r = '0;
        r.aluOutLoad = 1'b1;
        m.aluSrcA = controlPkg::SRCA_PC;
        m.aluSrcB = controlPkg::SRCB_BRANCH;
        r.aluOp = controlPkg::ALU_ADD;
        pushCycle(m, r);
        m = '0;
        r = '0;
        r.loadAB = 1'b1;
        pushCycle(m, r);
    endtask

    task automatic aluCycles(input controlPkg::aluOp_t op, input logic isImm,
                             input logic traps, input logic ovf);
        controlPkg::muxSel_t  m;
        controlPkg::regCtrl_t r;
        m = '0;
        r = '0;
        r.aluOutLoad = 1'b1;
        m.aluSrcA = controlPkg::SRCA_REG;
        m.aluSrcB = isImm ? controlPkg::SRCB_IMM : controlPkg::SRCB_REG;
        r.aluOp = op;
        pushCycle(m, r);
        m = '0;
        r = '0;
        if (traps && ovf) begin
            r.epcWrite = 1'b1;
            m.exCause = controlPkg::EXC_OVERFLOW;
        end else begin
            r.regWrite = 1'b1;
            m.wdReg = controlPkg::WD_ALUOUT;
            m.wrReg = isImm ? controlPkg::WR_RT : controlPkg::WR_RD;
        end
        pushCycle(m, r);
    endtask

    task automatic shiftCycles(input controlPkg::shiftCtrl_t dir, input logic byImm);
        controlPkg::muxSel_t  m;
        controlPkg::regCtrl_t r;
        m = '0;
        r = '0;
        r.shiftCtrl = controlPkg::SH_LOAD;
        m.shiftIn = byImm ? controlPkg::SHIN_B : controlPkg::SHIN_A;
        m.shiftS = byImm ? controlPkg::SHAMT_IMM : controlPkg::SHAMT_REG;
        pushCycle(m, r);
        m = '0;
        r = '0;
        r.shiftCtrl = dir;
        pushCycle(m, r);
        m = '0;
        r = '0;
        r.regWrite = 1'b1;
        m.wrReg = controlPkg::WR_RD;
        m.wdReg = controlPkg::WD_SHIFT;
        pushCycle(m, r);
    endtask

    task automatic branchCycles(input logic isBne);
        controlPkg::muxSel_t  m;
        controlPkg::regCtrl_t r;
        m = '0;
        r = '0;
        r.eqCond = !isBne;
        r.neCond = isBne;
        m.pcSource = controlPkg::PC_ALUOUT;
        m.aluSrcA = controlPkg::SRCA_REG;
        m.aluSrcB = controlPkg::SRCB_REG;
        r.aluOp = controlPkg::ALU_SUB;
        pushCycle(m, r);
        pushCycle('0, '0);
    endtask

    task automatic trapCycle();
        controlPkg::muxSel_t  m;
        controlPkg::regCtrl_t r;
        m = '0;
        r = '0;
        r.epcWrite = 1'b1;
        m.exCause = controlPkg::EXC_OPCODE;
        pushCycle(m, r);
    endtask

    // Reference table of the kept instruction set
    task automatic buildExpected(input controlPkg::opcode_t op, input controlPkg::funct_t fn,
                                 input logic ovf);
        expMux.delete();
        expReg.delete();
        fetchDecodeCycles();
        case (op)
            controlPkg::OP_RTYPE: begin
                case (fn)
                    controlPkg::FUNCT_ADD:  aluCycles(controlPkg::ALU_ADD, 1'b0, 1'b1, ovf);
                    controlPkg::FUNCT_SUB:  aluCycles(controlPkg::ALU_SUB, 1'b0, 1'b1, ovf);
                    controlPkg::FUNCT_AND:  aluCycles(controlPkg::ALU_AND, 1'b0, 1'b0, ovf);
                    controlPkg::FUNCT_SLL:  shiftCycles(controlPkg::SH_LEFT, 1'b1);
                    controlPkg::FUNCT_SLLV: shiftCycles(controlPkg::SH_LEFT, 1'b0);
                    controlPkg::FUNCT_SRA:  shiftCycles(controlPkg::SH_RIGHT_ARITH, 1'b1);
                    controlPkg::FUNCT_SRAV: shiftCycles(controlPkg::SH_RIGHT_ARITH, 1'b0);
                    controlPkg::FUNCT_SRL:  shiftCycles(controlPkg::SH_RIGHT_LOGIC, 1'b1);
                    default:                trapCycle();
                endcase
            end
            controlPkg::OP_ADDI:  aluCycles(controlPkg::ALU_ADD, 1'b1, 1'b1, ovf);
            controlPkg::OP_ADDIU: aluCycles(controlPkg::ALU_ADD, 1'b1, 1'b0, ovf);
            controlPkg::OP_BEQ:   branchCycles(1'b0);
            controlPkg::OP_BNE:   branchCycles(1'b1);
            default:              trapCycle();
        endcase
    endtask

    // Starts on the falling edge of the first fetch cycle and ends on the next one
    task automatic runInstr(input controlPkg::opcode_t op, input controlPkg::funct_t fn,
                            input logic ovf, input string label);
        int i;
        opcode = op;
        funct = fn;
        overflow = ovf;
        buildExpected(op, fn, ovf);
        for (i = 0; i < expMux.size(); i++) begin
            checkOutputs(expMux[i], expReg[i], label, i);
            @(negedge clk);
        end
    endtask

    task automatic resetTest();
        controlPkg::muxSel_t  m;
        controlPkg::regCtrl_t r;
        int                   i;
        openTest("reset");
        for (i = 0; i < ResetCycles; i++) begin
            @(negedge clk);
            checkOutputs('0, '0, "in reset", i);
        end
        rstN = 1'b1;
        @(negedge clk);
        m = '0;
        r = '0;
        r.regWrite = 1'b1;
        m.wrReg = controlPkg::WR_SP;
        m.wdReg = controlPkg::WD_SP_INIT;
        checkOutputs(m, r, "stack pointer init", 0);
        @(negedge clk);
        runInstr(controlPkg::OP_ADDIU, '0, 1'b0, "first ADDIU");
        closeTest();
    endtask

    task automatic aluTest(input logic ovf, input string name);
        openTest(name);
        runInstr(controlPkg::OP_RTYPE, controlPkg::FUNCT_ADD, ovf, "ADD");
        runInstr(controlPkg::OP_RTYPE, controlPkg::FUNCT_SUB, ovf, "SUB");
        runInstr(controlPkg::OP_RTYPE, controlPkg::FUNCT_AND, ovf, "AND");
        runInstr(controlPkg::OP_ADDI, 6'h15, ovf, "ADDI");
        runInstr(controlPkg::OP_ADDIU, 6'h2a, ovf, "ADDIU");
        closeTest();
    endtask

    task automatic shiftTest();
        openTest("shift");
        runInstr(controlPkg::OP_RTYPE, controlPkg::FUNCT_SLL, 1'b0, "SLL");
        runInstr(controlPkg::OP_RTYPE, controlPkg::FUNCT_SLLV, 1'b0, "SLLV");
        runInstr(controlPkg::OP_RTYPE, controlPkg::FUNCT_SRA, 1'b1, "SRA");
        runInstr(controlPkg::OP_RTYPE, controlPkg::FUNCT_SRAV, 1'b0, "SRAV");
        runInstr(controlPkg::OP_RTYPE, controlPkg::FUNCT_SRL, 1'b0, "SRL");
        closeTest();
    endtask

    task automatic branchTest();
        openTest("branch");
        runInstr(controlPkg::OP_BEQ, 6'h3f, 1'b0, "BEQ");
        runInstr(controlPkg::OP_BNE, 6'h00, 1'b1, "BNE");
        closeTest();
    endtask

    task automatic illegalTest();
        logic [31:0] rnd;
        int          i;
        openTest("illegal");
        runInstr(6'b100_011, '0, 1'b0, "LW");
        runInstr(6'b000_010, '0, 1'b0, "J");
        runInstr(controlPkg::OP_RTYPE, 6'b011_010, 1'b1, "DIV");
        for (i = 0; i < 20; i++) begin
            rnd = $random(seed);
            runInstr(rnd[5:0], rnd[11:6], rnd[12], $sformatf("random %0d", i));
        end
        // Fetch must resume after the last instruction
        fetchDecodeCycles();
        checkOutputs(expMux[expMux.size() - 6], expReg[expReg.size() - 6], "final fetch", 0);
        closeTest();
    endtask

    initial begin
        int assertFails;
        rstN = 1'b0;
        opcode = controlPkg::OP_ADDIU;
        funct = '0;
        overflow = 1'b0;
        resetTest();
        aluTest(1'b0, "alu");
        aluTest(1'b1, "overflow");
        shiftTest();
        branchTest();
        illegalTest();
        assertFails = u_dut.u_checks.failCount;
        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests, failedTests, checks, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb.f
source/controlPkg.sv
source/instrDecoder.sv
source/controlSequencer.sv
source/controlSignalGen.sv
source/controlUnit.sv
tests/controlUnit_assertions.sv
tests/controlUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= controlUnitTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
